//--- sources.f
+incdir+include
verilog/spu_pkg.sv
verilog/scan_counters.sv
verilog/sprite_regs.sv
verilog/sprite_fsm.sv
verilog/line_buffer.sv
verilog/spu_top.sv
testbench/spu_props.sv
testbench/tb_spu.sv

//--- testbench/tb_spu.sv
`timescale 1ns/1ps
`default_nettype none

`include "spu_defs.svh"

module tb_spu;

	import spu_pkg::*;

	localparam int NROWS   = 5;
	localparam int NSLOT   = NROWS * 3;                         // three sprites per row
	localparam int FRAME_L = 8;                                 // lines per frame
	localparam int LINE_CK = `SPU_LINE_PIX * 4;                 // clocks per line
	localparam int LIMIT   = (NROWS * 2 + 1) * FRAME_L * LINE_CK * 11 / 10;
	localparam int LAST_A  = (1 << `SPU_COORD_W) - 1;           // last buffer address

	logic                     clk;
	logic                     rst_n;
	logic                     spu_en;
	logic                     pre_hline;
	logic                     pre_vline;
	logic                     cbeg;
	logic [7:0]               sfile_data;
	logic [`SPU_SFILE_AW-1:0] sfile_addr;
	pix_color_t               spixel;
	pix_pri_t                 spixel_pri;
	logic                     spixel_en;

	logic [7:0] sfile_mem [1 << `SPU_SFILE_AW];               // descriptor memory model

	// scene table with slot r*3+k in row r
	logic   row_en  [NROWS];
	int     row_lit [NROWS];    // lit pixels over lines 1..7
	int     s_num   [NSLOT];    // sprite number or -1 when unused
	int     s_x     [NSLOT];
	int     s_y     [NSLOT];
	int     s_wf    [NSLOT];    // width field
	int     s_hf    [NSLOT];    // height field
	int     s_act   [NSLOT];
	int     s_col   [NSLOT];
	int     s_pri   [NSLOT];

	integer seed;
	int     cyc;
	int     lit_cnt;
	int     cur_row;
	logic   cur_en;
	int     prev_row;           // pixel now on the outputs
	int     prev_line;
	int     prev_x;
	logic   prev_chk;

	spu_top u_spu_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.spu_en     (spu_en),
		.pre_hline  (pre_hline),
		.pre_vline  (pre_vline),
		.cbeg       (cbeg),
		.sfile_data (sfile_data),
		.sfile_addr (sfile_addr),
		.spixel     (spixel),
		.spixel_pri (spixel_pri),
		.spixel_en  (spixel_en)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
		sfile_data <= sfile_mem[sfile_addr];                    // one clock of latency

	initial
	begin
		cyc = 0;
		forever
		begin
			@(posedge clk);
			cyc = cyc + 1;
			if (cyc >= LIMIT)
				abort_run($sformatf("timeout, frames not finished after %0d clocks", cyc));
		end
	end

	// ------------------------------------------------------------
	// reporting and compare tasks
	// ------------------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_color(input pix_color_t got, input pix_color_t exp, input int l, input int x);
		if (got !== exp)
			abort_run($sformatf("Mismatch at %0t: line %0d pixel %0d colour %h, expected %h",
				$time, l, x, got, exp));
	endtask

	task automatic check_pri(input pix_pri_t got, input pix_pri_t exp, input int l, input int x);
		if (got !== exp)
			abort_run($sformatf("Mismatch at %0t: line %0d pixel %0d priority %h, expected %h",
				$time, l, x, got, exp));
	endtask

	task automatic check_en(input logic got, input logic exp, input int l, input int x);
		if (got !== exp)
			abort_run($sformatf("Mismatch at %0t: line %0d pixel %0d enable %b, expected %b",
				$time, l, x, got, exp));
	endtask

	task automatic verify_lit_count(input int r);
		if (lit_cnt != row_lit[r])
			abort_run($sformatf("Mismatch at %0t: row %0d lit %0d pixels, expected %0d",
				$time, r, lit_cnt, row_lit[r]));
	endtask

	// ------------------------------------------------------------
	// scene table and descriptor memory
	// ------------------------------------------------------------
	task automatic put_sprite(input int r, input int k, input int num, input int x, input int y,
		input int wf, input int hf, input int act, input int col, input int pri);
		int idx;
		idx        = r * 3 + k;
		s_num[idx] = num;
		s_x[idx]   = x;
		s_y[idx]   = y;
		s_wf[idx]  = wf;
		s_hf[idx]  = hf;
		s_act[idx] = act;
		s_col[idx] = col & 63;
		s_pri[idx] = pri;
	endtask

	task automatic fill_table();
		for (int i = 0; i < NSLOT; i++)
			s_num[i] = -1;
		// renderer off with a sprite present
		row_en[0]  = 1'b0;
		row_lit[0] = 0;
		put_sprite(0, 0, 0, 16, 0, 1, 1, 1, 'h0f, 1);
		// one sprite plus an inactive one over the corner
		row_en[1]  = 1'b1;
		row_lit[1] = 120;
		put_sprite(1, 0, 5, 100, 3, 2, 0, 1, 'h2a, 2);
		put_sprite(1, 1, 9, 0, 0, 3, 3, 0, 'h3f, 3);
		// 7 overlaps 2 and wins
		// sprite 20 misses lines 1..5
		row_en[2]  = 1'b1;
		row_lit[2] = 264;
		put_sprite(2, 0, 2, 50, 0, 3, 1, 1, 'h11, 1);
		put_sprite(2, 1, 7, 70, 2, 1, 0, 1, 'h3c, 3);
		put_sprite(2, 2, 20, 200, 6, 0, 0, 1, 'h05, 0);
		// earlier sprites gone and last descriptor used
		row_en[3]  = 1'b1;
		row_lit[3] = 24;
		put_sprite(3, 0, 31, 300, 5, 0, 0, 1, 'h01, 2);
		// random colours against the right edge and end of buffer
		row_en[4]  = 1'b1;
		row_lit[4] = 88;
		put_sprite(4, 0, 3, 440, 0, 3, 1, 1, $random(seed), 1);
		put_sprite(4, 1, 4, 480, 1, 7, 0, 1, $random(seed), 2);
		put_sprite(4, 2, 10, 0, 4, 0, 0, 1, $random(seed), 3);
	endtask

	task automatic load_row(input int r);
		int idx;
		int base;
		for (int a = 0; a < (1 << `SPU_SFILE_AW); a++)
			sfile_mem[a] = '0;                                   // all others inactive
		for (int k = 0; k < 3; k++)
		begin
			idx = r * 3 + k;
			if (s_num[idx] >= 0)
			begin
				base = s_num[idx] * `SPU_DESC_BYTES;
				sfile_mem[base + 0] = 8'(s_x[idx]);
				sfile_mem[base + 1] = 8'((s_wf[idx] << 1) | (s_x[idx] >> 8));
				sfile_mem[base + 2] = 8'(s_y[idx]);
				sfile_mem[base + 3] = 8'((s_act[idx] << 7) | (s_hf[idx] << 1) | (s_y[idx] >> 8));
				sfile_mem[base + 4] = 8'((s_pri[idx] << 6) | s_col[idx]);
			end
		end
	endtask

	// ------------------------------------------------------------
	// reference image and pixel compare
	// ------------------------------------------------------------
	// highest numbered sprite covering the pixel wins, nothing drawn when disabled
	task automatic expect_pixel(input int r, input int l, input int x,
		output pix_color_t col, output pix_pri_t pri, output logic en);
		int best;
		int idx;
		best = -1;
		col  = '0;
		pri  = '0;
		en   = 1'b0;
		for (int k = 0; k < 3; k++)
		begin
			idx = r * 3 + k;
			if (row_en[r] && (s_num[idx] > best) && (s_act[idx] != 0)
				&& (l >= s_y[idx]) && (l < s_y[idx] + (s_hf[idx] + 1) * `SPU_SIZE_UNIT)
				&& (x >= s_x[idx]) && (x < s_x[idx] + (s_wf[idx] + 1) * `SPU_SIZE_UNIT)
				&& (x <= LAST_A))
			begin
				best = s_num[idx];
				col  = pix_color_t'(s_col[idx]);
				pri  = pix_pri_t'(s_pri[idx]);
				en   = 1'b1;
			end
		end
	endtask

	task automatic compare_pixel(input int r, input int l, input int x);
		pix_color_t ecol;
		pix_pri_t   epri;
		logic       een;
		expect_pixel(r, l, x, ecol, epri, een);
		check_en(spixel_en, een, l, x);
		check_color(spixel, ecol, l, x);
		check_pri(spixel_pri, epri, l, x);
		if ((l == 1) && (x == 0))
			lit_cnt = 0;                                         // first checked pixel
		if (spixel_en)
			lit_cnt = lit_cnt + 1;
		if ((l == FRAME_L - 1) && (x == `SPU_LINE_PIX - 1))
			verify_lit_count(r);
	endtask

	// ------------------------------------------------------------
	// timing generator
	// ------------------------------------------------------------
	task automatic run_line(input int l, input logic chk);
		for (int x = 0; x < `SPU_LINE_PIX; x++)
		begin
			for (int ph = 0; ph < 4; ph++)
			begin
				@(posedge clk);
				cbeg      <= (ph == 0);
				pre_hline <= (ph == 0) && (x == 0);              // line start with a cbeg
				pre_vline <= (ph == 0) && (x == 0) && (l == 0);
				spu_en    <= cur_en;
				if (ph == 0)
				begin
					@(negedge clk);                              // previous slot still held
					if (prev_chk)
						compare_pixel(prev_row, prev_line, prev_x);
					prev_row  = cur_row;
					prev_line = l;
					prev_x    = x;
					prev_chk  = chk;
				end
			end
		end
	endtask

	// line 0 shows the wrap-around render and is skipped
	task automatic run_frame(input logic chk);
		for (int l = 0; l < FRAME_L; l++)
			run_line(l, chk && (l != 0));
	endtask

	initial
	begin
		rst_n      = 1'b0;
		spu_en     = 1'b0;
		pre_hline  = 1'b0;
		pre_vline  = 1'b0;
		cbeg       = 1'b0;
		sfile_data = '0;
		seed       = 32'h0924_d1c8;
		lit_cnt    = 0;
		cur_row    = 0;
		cur_en     = 1'b0;
		prev_row   = 0;
		prev_line  = 0;
		prev_x     = 0;
		prev_chk   = 1'b0;
		for (int a = 0; a < (1 << `SPU_SFILE_AW); a++)
			sfile_mem[a] = '0;
		fill_table();
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		run_frame(1'b0);                                         // warm-up clears both halves
		for (int r = 0; r < NROWS; r++)
		begin
			@(negedge clk);
			cur_row = r;
			cur_en  = row_en[r];
			load_row(r);
			run_frame(1'b0);
			run_frame(1'b1);
		end
		run_line(0, 1'b0);                                       // last checked pixel comes out
		if (u_spu_top.u_sprite_fsm.u_spu_props.assert_errs == 0)
		begin
			$display("Simulation completed successfully");
			$finish;
		end
		else
			abort_run("sprite FSM assertions failed during the run");
	end

endmodule

`default_nettype wire

//--- testbench/spu_props.sv
`timescale 1ns/1ps
`default_nettype none

module spu_props (
	input logic                clk,
	input logic                rst_n,
	input logic                spu_en,
	input logic                pre_hline,
	input spu_pkg::spu_state_e state,
	input logic                lb_we,
	input logic                desc_load
);

	import spu_pkg::*;

	int assert_errs = 0;    // failures seen so far

	// ------------------------------------------------------------
	// sequencer rules
	// ------------------------------------------------------------
	// line buffer written only while a span is drawn
	a_we_draw: assert property (@(posedge clk) disable iff (!rst_n)
		lb_we |-> (state == ST_DRAW))
	else
	begin
		assert_errs++;
		$error("lb_we high outside ST_DRAW");
	end

	a_load_halt: assert property (@(posedge clk) disable iff (!rst_n)
		!(desc_load && (state == ST_HALT)))                 // halted FSM reads nothing
	else
	begin
		assert_errs++;
		$error("desc_load while halted");
	end

	a_off_halt: assert property (@(posedge clk) disable iff (!rst_n)
		(pre_hline && !spu_en) |=> (state == ST_HALT))
	else
	begin
		assert_errs++;
		$error("line start with renderer disabled did not halt");
	end

endmodule

bind sprite_fsm spu_props u_spu_props (
	.clk       (clk),
	.rst_n     (rst_n),
	.spu_en    (spu_en),
	.pre_hline (pre_hline),
	.state     (state),
	.lb_we     (lb_we),
	.desc_load (desc_load)
);

`default_nettype wire

//--- verilog/spu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "spu_defs.svh"

module spu_top (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      spu_en,
	input  logic                      pre_hline,
	input  logic                      pre_vline,
	input  logic                      cbeg,
	input  logic [7:0]                sfile_data,   // one clock after sfile_addr
	output logic [`SPU_SFILE_AW-1:0]  sfile_addr,
	output spu_pkg::pix_color_t       spixel,
	output spu_pkg::pix_pri_t         spixel_pri,
	output logic                      spixel_en
);

	import spu_pkg::*;

	coord_t      vline;
	coord_t      pix_x;
	desc_field_e desc_field;
	logic        desc_load;
	logic        active;
	logic        line_hit;
	coord_t      xpos;
	coord_t      xsize;
	pix_color_t  color;
	pix_pri_t    pri;
	logic        lb_we;
	coord_t      lb_waddr;
	pix_color_t  lb_color;
	pix_pri_t    lb_pri;

	// ---------------------------------------------------------
	// raster position
	// ---------------------------------------------------------
	scan_counters u_scan_counters (
		.clk        (clk),
		.rst_n      (rst_n),
		.pre_hline  (pre_hline),
		.pre_vline  (pre_vline),
		.cbeg       (cbeg),
		.vline      (vline),
		.pix_x      (pix_x)
	);

	// ---------------------------------------------------------
	// renderer, descriptor regs beside their sequencer
	// ---------------------------------------------------------
	sprite_regs u_sprite_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.desc_load  (desc_load),
		.desc_field (desc_field),
		.sfile_data (sfile_data),
		.vline      (vline),
		.active     (active),
		.line_hit   (line_hit),
		.xpos       (xpos),
		.xsize      (xsize),
		.color      (color),
		.pri        (pri)
	);

	sprite_fsm u_sprite_fsm (
		.clk        (clk),
		.rst_n      (rst_n),
		.spu_en     (spu_en),
		.pre_hline  (pre_hline),
		.vline      (vline),
		.active     (active),
		.line_hit   (line_hit),
		.xpos       (xpos),
		.xsize      (xsize),
		.color      (color),
		.pri        (pri),
		.sfile_addr (sfile_addr),
		.desc_field (desc_field),
		.desc_load  (desc_load),
		.lb_we      (lb_we),
		.lb_waddr   (lb_waddr),
		.lb_color   (lb_color),
		.lb_pri     (lb_pri)
	);

	// ---------------------------------------------------------
	// display side
	// ---------------------------------------------------------
	line_buffer u_line_buffer (
		.clk        (clk),
		.rst_n      (rst_n),
		.cbeg       (cbeg),
		.pix_x      (pix_x),
		.disp_buf   (vline[0]),      // even lines show buffer 0
		.lb_we      (lb_we),
		.lb_waddr   (lb_waddr),
		.lb_color   (lb_color),
		.lb_pri     (lb_pri),
		.spixel     (spixel),
		.spixel_pri (spixel_pri),
		.spixel_en  (spixel_en)
	);

endmodule

`default_nettype wire

//--- verilog/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "spu_defs.svh"

module line_buffer (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                cbeg,
	input  spu_pkg::coord_t     pix_x,
	input  logic                disp_buf,     // buffer shown this line
	input  logic                lb_we,
	input  spu_pkg::coord_t     lb_waddr,
	input  spu_pkg::pix_color_t lb_color,
	input  spu_pkg::pix_pri_t   lb_pri,
	output spu_pkg::pix_color_t spixel,
	output spu_pkg::pix_pri_t   spixel_pri,
	output logic                spixel_en
);

	import spu_pkg::*;

	localparam int WORD_W = 1 + `SPU_PRI_W + `SPU_COLOR_W;   // {valid, pri, colour}
	localparam int DEPTH  = 1 << `SPU_COORD_W;

	logic [WORD_W-1:0] wr_word;
	logic [WORD_W-1:0] rd_word;
	logic [1:0]        cbeg_sr;       // cbeg delayed 1 and 2 clocks

	assign wr_word = {1'b1, lb_pri, lb_color};

	// ---------------------------------------------------------
	// ping-pong line RAMs
	// ---------------------------------------------------------
	for (genvar b = 0; b < 2; b++)
	begin : g_buf
		logic [WORD_W-1:0] mem [DEPTH];
		logic [WORD_W-1:0] q;
		logic              is_disp;
		logic              we;
		coord_t            wa;
		logic [WORD_W-1:0] wd;

		assign is_disp = (disp_buf == 1'(b));
		assign we      = is_disp ? cbeg : lb_we;        // display side only clears
		assign wa      = is_disp ? pix_x : lb_waddr;
		assign wd      = is_disp ? '0 : wr_word;        // transparent after read

		always_ff @(posedge clk)
		begin
			if (we)
				mem[wa] <= wd;
			q <= mem[pix_x];
		end
	end

	// disp_buf only moves on line start, stable between read and output
	assign rd_word = disp_buf ? g_buf[1].q : g_buf[0].q;

	// ---------------------------------------------------------
	// pixel output
	// ---------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cbeg_sr <= '0;
		else
			cbeg_sr <= {cbeg_sr[0], cbeg};
	end

	// loads two clocks after pix_x steps, held for the whole slot
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			spixel     <= '0;
			spixel_pri <= '0;
			spixel_en  <= 1'b0;
		end
		else if (cbeg_sr[1])
			{spixel_en, spixel_pri, spixel} <= rd_word;
	end

endmodule

`default_nettype wire

//--- verilog/sprite_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "spu_defs.svh"

module sprite_fsm (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       spu_en,
	input  logic                       pre_hline,
	input  spu_pkg::coord_t            vline,
	input  logic                       active,
	input  logic                       line_hit,
	input  spu_pkg::coord_t            xpos,
	input  spu_pkg::coord_t            xsize,       // width minus one
	input  spu_pkg::pix_color_t        color,
	input  spu_pkg::pix_pri_t          pri,
	output logic [`SPU_SFILE_AW-1:0]   sfile_addr,
	output spu_pkg::desc_field_e       desc_field,  // byte arriving on sfile_data
	output logic                       desc_load,
	output logic                       lb_we,
	output spu_pkg::coord_t            lb_waddr,
	output spu_pkg::pix_color_t        lb_color,
	output spu_pkg::pix_pri_t          lb_pri
);

	import spu_pkg::*;

	localparam int AW   = `SPU_SFILE_AW;
	localparam int SN_W = $clog2(`SPU_NUM_SPRITES);

	spu_state_e      state;
	logic [SN_W-1:0] snum;          // sprite being processed
	coord_t          span_cnt;      // pixels left after the current one
	desc_field_e     rd_field;      // byte requested this cycle
	coord_t          next_line;
	logic            next_vis;
	logic            last_sprite;
	logic            span_end;

	assign next_line   = vline + 1'b1;                // line the counter steps to
	assign next_vis    = (next_line < `SPU_VIS_LINES);
	assign last_sprite = (snum == SN_W'(`SPU_NUM_SPRITES - 1));
	assign span_end    = (span_cnt == '0) || (&lb_waddr);   // width done or right edge

	// ---------------------------------------------------------
	// descriptor reads, data returns one clock later
	// ---------------------------------------------------------
	always_comb
	begin
		case (state)
			ST_YLO:   rd_field = DF_YPOS_L;
			ST_YHI:   rd_field = DF_YCTL;
			ST_CHECK: rd_field = DF_XPOS_L;           // speculative, dropped on a miss
			ST_XLO:   rd_field = DF_XCTL;
			ST_XHI:   rd_field = DF_ATTR;
			default:  rd_field = DF_YPOS_L;
		endcase
	end

	assign sfile_addr = AW'(snum * `SPU_DESC_BYTES + rd_field);

	// load strobe trails the request by one state
	always_comb
	begin
		desc_load  = 1'b1;
		desc_field = DF_YPOS_L;
		case (state)
			ST_YHI:   desc_field = DF_YPOS_L;
			ST_CHECK: desc_field = DF_YCTL;
			ST_XLO:   desc_field = DF_XPOS_L;
			ST_XHI:   desc_field = DF_XCTL;
			ST_ATTR:  desc_field = DF_ATTR;
			default:  desc_load  = 1'b0;
		endcase
	end

	// ---------------------------------------------------------
	// sequencer
	// ---------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_HALT;
			snum  <= '0;
		end
		else if (pre_hline)
		begin
			snum  <= '0;                              // unfinished work is dropped
			state <= (spu_en && next_vis) ? ST_YLO : ST_HALT;
		end
		else
		begin
			case (state)
				ST_HALT:  state <= ST_HALT;
				ST_YLO:   state <= ST_YHI;
				ST_YHI:   state <= ST_CHECK;
				ST_CHECK: state <= (active && line_hit) ? ST_XLO : ST_NEXT;
				ST_XLO:   state <= ST_XHI;
				ST_XHI:   state <= ST_ATTR;
				ST_ATTR:  state <= ST_DRAW;
				ST_DRAW:
				begin
					if (span_end)
						state <= ST_NEXT;
				end
				ST_NEXT:
				begin
					if (last_sprite)
						state <= ST_HALT;
					else
					begin
						snum  <= snum + 1'b1;
						state <= ST_YLO;
					end
				end
				default:  state <= ST_HALT;
			endcase
		end
	end

	// span walker, xpos and xsize are complete by ST_ATTR
	always_ff @(posedge clk)
	begin
		if (state == ST_ATTR)
		begin
			lb_waddr <= xpos;
			span_cnt <= xsize;
		end
		else if ((state == ST_DRAW) && !span_end)
		begin
			lb_waddr <= lb_waddr + 1'b1;
			span_cnt <= span_cnt - 1'b1;
		end
	end

	assign lb_we    = (state == ST_DRAW);    // one pixel per clock
	assign lb_color = color;                  // solid fill from the attribute byte
	assign lb_pri   = pri;

endmodule

`default_nettype wire

//--- verilog/sprite_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "spu_defs.svh"

module sprite_regs (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 desc_load,    // capture the byte on sfile_data
	input  spu_pkg::desc_field_e desc_field,   // which byte that is
	input  logic [7:0]           sfile_data,
	input  spu_pkg::coord_t      vline,
	output logic                 active,
	output logic                 line_hit,     // active and covers vline + 1
	output spu_pkg::coord_t      xpos,
	output spu_pkg::coord_t      xsize,        // width minus one
	output spu_pkg::pix_color_t  color,
	output spu_pkg::pix_pri_t    pri
);

	import spu_pkg::*;

	coord_t ypos_r;
	coord_t ysize_r;      // height minus one
	logic   active_r;
	logic   yctl_now;
	coord_t eff_ypos;
	coord_t eff_ysize;
	coord_t target;
	coord_t line_ofs;

	// field 0..63 -> last pixel offset 7..511, fits in 9 bits
	function automatic coord_t size_m1(input logic [5:0] field);
		return coord_t'(field * `SPU_SIZE_UNIT + (`SPU_SIZE_UNIT - 1));
	endfunction

	// ---------------------------------------------------------
	// descriptor field capture
	// ---------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			active_r <= 1'b0;
		else if (desc_load && (desc_field == DF_YCTL))
			active_r <= sfile_data[7];
	end

	always_ff @(posedge clk)
	begin
		if (desc_load)
		begin
			case (desc_field)
				DF_XPOS_L: xpos[7:0] <= sfile_data;
				DF_XCTL:
				begin
					xpos[8] <= sfile_data[0];
					xsize   <= size_m1(sfile_data[6:1]);
				end
				DF_YPOS_L: ypos_r[7:0] <= sfile_data;
				DF_YCTL:
				begin
					ypos_r[8] <= sfile_data[0];
					ysize_r   <= size_m1(sfile_data[6:1]);
				end
				DF_ATTR:
				begin
					pri   <= sfile_data[7:6];
					color <= sfile_data[5:0];
				end
				default: ;                            // bytes 5..7 ignored
			endcase
		end
	end

	// ---------------------------------------------------------
	// target line test
	// ---------------------------------------------------------
	// the y control byte is still on the bus during the check, so bypass it
	assign yctl_now  = desc_load && (desc_field == DF_YCTL);
	assign eff_ypos  = yctl_now ? {sfile_data[0], ypos_r[7:0]} : ypos_r;
	assign eff_ysize = yctl_now ? size_m1(sfile_data[6:1]) : ysize_r;
	assign active    = yctl_now ? sfile_data[7] : active_r;

	assign target   = vline + 1'b1;                 // line being rendered
	assign line_ofs = target - eff_ypos;              // row inside the sprite
	assign line_hit = active && (target >= eff_ypos) && (line_ofs <= eff_ysize);

endmodule

`default_nettype wire

//--- verilog/scan_counters.sv
`timescale 1ns/1ps
`default_nettype none

`include "spu_defs.svh"

module scan_counters (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            pre_hline,    // line start, comes with a cbeg
	input  logic            pre_vline,    // frame start, only with pre_hline
	input  logic            cbeg,         // one pixel slot every 4 clocks
	output spu_pkg::coord_t vline,
	output spu_pkg::coord_t pix_x
);

	import spu_pkg::*;

	// ---------------------------------------------------------
	// line counter
	// ---------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			vline <= '0;
		else if (pre_hline)
			vline <= pre_vline ? coord_t'(0) : coord_t'(vline + 1'b1);   // frame restart wins
	end

	// ---------------------------------------------------------
	// pixel slot counter
	// ---------------------------------------------------------
	// parks on the last slot if no line strobe shows up in time
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pix_x <= '0;
		else if (pre_hline)
			pix_x <= '0;                                  // beats the coincident cbeg
		else if (cbeg && (pix_x != coord_t'(`SPU_LINE_PIX - 1)))
			pix_x <= pix_x + 1'b1;
	end

endmodule

`default_nettype wire

//--- verilog/spu_pkg.sv
`default_nettype none

`include "spu_defs.svh"

package spu_pkg;

	typedef logic [`SPU_COORD_W-1:0] coord_t;      // line, pixel, buffer addr
	typedef logic [`SPU_COLOR_W-1:0] pix_color_t;
	typedef logic [`SPU_PRI_W-1:0]   pix_pri_t;

	// byte index within one descriptor, 5..7 unused
	typedef enum logic [2:0] {
		DF_XPOS_L = 3'd0,   // x[7:0]
		DF_XCTL   = 3'd1,   // [0] x[8], [6:1] width field
		DF_YPOS_L = 3'd2,   // y[7:0]
		DF_YCTL   = 3'd3,   // [0] y[8], [6:1] height field, [7] active
		DF_ATTR   = 3'd4    // [7:6] priority, [5:0] colour
	} desc_field_e;

	typedef enum logic [3:0] {
		ST_HALT, ST_YLO, ST_YHI, ST_CHECK, ST_XLO, ST_XHI, ST_ATTR, ST_DRAW, ST_NEXT
	} spu_state_e;

endpackage

`default_nettype wire

//--- include/spu_defs.svh
`ifndef SPU_DEFS_SVH
`define SPU_DEFS_SVH

// ---------------------------------------------------------
// sprite table layout
// ---------------------------------------------------------
`define SPU_NUM_SPRITES 32    // descriptors walked per line
`define SPU_DESC_BYTES  8     // bytes per descriptor, addr = num * 8 + field
`define SPU_SFILE_AW    8     // descriptor memory address width

// ---------------------------------------------------------
// raster geometry
// ---------------------------------------------------------
`define SPU_COORD_W     9     // line, pixel and line buffer address width
`define SPU_LINE_PIX    448   // pixel slots per line
`define SPU_VIS_LINES   288   // renderer halted at or past this line

// size field granule, pixels = (field + 1) * unit
`define SPU_SIZE_UNIT   8

// ---------------------------------------------------------
// pixel word
// ---------------------------------------------------------
`define SPU_COLOR_W     6     // colour index
`define SPU_PRI_W       2     // priority against other layers

`endif
